// File: src/vga_pkg.sv
package vga_pkg;

    typedef logic [10:0] coord_t;     // pixel or line count / coordinate
    typedef logic [8:0]  rgb9_t;      // {r[2:0], g[2:0], b[2:0]}
    typedef logic [3:0]  chan4_t;     // one dac channel
    typedef logic [4:0]  apb_addr_t;  // byte address, 8 words
    typedef logic [31:0] apb_data_t;

    // default timing, 1280x1024 @ 108 MHz pixel clock
    localparam coord_t def_h_disp  = 11'd1280;
    localparam coord_t def_h_front = 11'd48;
    localparam coord_t def_h_sync  = 11'd112;
    localparam coord_t def_h_total = 11'd1688;  // back porch 248
    localparam coord_t def_v_disp  = 11'd1024;
    localparam coord_t def_v_front = 11'd1;
    localparam coord_t def_v_sync  = 11'd3;
    localparam coord_t def_v_total = 11'd1066;  // back porch 38

    localparam coord_t def_barw = 11'd160;      // 8 bars across 1280

    // register map
    localparam apb_addr_t reg_ctrl   = 5'h00;
    localparam apb_addr_t reg_solid  = 5'h04;
    localparam apb_addr_t reg_barw   = 5'h08;
    localparam apb_addr_t reg_htime0 = 5'h0C;   // front[26:16], disp[10:0]
    localparam apb_addr_t reg_htime1 = 5'h10;   // total[26:16], sync[10:0]
    localparam apb_addr_t reg_vtime0 = 5'h14;   // same layout, in lines
    localparam apb_addr_t reg_vtime1 = 5'h18;
    localparam apb_addr_t reg_status = 5'h1C;   // read only

    // ctrl fields, bit positions
    localparam int ctrl_enable = 0;
    localparam int ctrl_mode   = 1;             // lsb of 2 bit field
    localparam int ctrl_hpol   = 3;
    localparam int ctrl_vpol   = 4;

    // pixel source select
    localparam logic [1:0] mode_ext   = 2'd0;
    localparam logic [1:0] mode_solid = 2'd1;
    localparam logic [1:0] mode_bars  = 2'd2;
    localparam logic [1:0] mode_blank = 2'd3;

    // colour bar sequence, octal digits map to r, g, b
    localparam rgb9_t bar_colors [8] = '{
        9'o777,   // white
        9'o700,   // red
        9'o707,   // magenta
        9'o770,   // yellow
        9'o070,   // green
        9'o007,   // blue
        9'o077,   // cyan
        9'o000    // black
    };

endpackage

// File: src/vga_apb_regs.sv
module vga_apb_regs (
    input  logic               clk_vga,
    input  logic               RST_N,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  vga_pkg::apb_addr_t paddr,
    input  vga_pkg::apb_data_t pwdata,
    input  logic               frame_start,  // from timer, last pixel of frame
    input  vga_pkg::coord_t    line,         // current v count
    output vga_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               enable,
    output logic [1:0]         mode,
    output logic               hs_pol,
    output logic               vs_pol,
    output vga_pkg::rgb9_t     solid,
    output vga_pkg::coord_t    barw,
    output vga_pkg::coord_t    h_disp,
    output vga_pkg::coord_t    h_front,
    output vga_pkg::coord_t    h_sync,
    output vga_pkg::coord_t    h_total,
    output vga_pkg::coord_t    v_disp,
    output vga_pkg::coord_t    v_front,
    output vga_pkg::coord_t    v_sync,
    output vga_pkg::coord_t    v_total
);

    logic [4:0]         ctrl_q;                  // pol, pol, mode, enable
    vga_pkg::rgb9_t     solid_q;
    vga_pkg::coord_t    barw_q;
    vga_pkg::coord_t    hd_q, hf_q, hs_q, ht_q;  // programmed timing
    vga_pkg::coord_t    vd_q, vf_q, vs_q, vt_q;
    logic [15:0]        frame_cnt;
    logic               access;                  // apb access phase
    logic               addr_hit;
    logic               wr_en;
    vga_pkg::apb_data_t rd_data;

    assign access = psel & penable;
    assign pready = 1'b1;                        // never stall
    // status is read only, writing it is an error
    assign pslverr = access & (~addr_hit | (pwrite & (paddr == vga_pkg::reg_status)));
    assign wr_en = access & pwrite & ~pslverr;

    always_comb
    begin
        addr_hit = 1'b1;
        rd_data = '0;
        case (paddr)
            vga_pkg::reg_ctrl:   rd_data = {27'd0, ctrl_q};
            vga_pkg::reg_solid:  rd_data = {23'd0, solid_q};
            vga_pkg::reg_barw:   rd_data = {21'd0, barw_q};
            vga_pkg::reg_htime0: rd_data = {5'd0, hf_q, 5'd0, hd_q};
            vga_pkg::reg_htime1: rd_data = {5'd0, ht_q, 5'd0, hs_q};
            vga_pkg::reg_vtime0: rd_data = {5'd0, vf_q, 5'd0, vd_q};
            vga_pkg::reg_vtime1: rd_data = {5'd0, vt_q, 5'd0, vs_q};
            vga_pkg::reg_status: rd_data = {frame_cnt, 5'd0, line};
            default:             addr_hit = 1'b0;  // unaligned offsets
        endcase
    end

    assign prdata = psel ? rd_data : '0;         // quiet bus when idle

    // programmed registers
    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
        begin
            ctrl_q  <= '0;                       // disabled out of reset
            solid_q <= '0;
            barw_q  <= vga_pkg::def_barw;
            hd_q    <= vga_pkg::def_h_disp;
            hf_q    <= vga_pkg::def_h_front;
            hs_q    <= vga_pkg::def_h_sync;
            ht_q    <= vga_pkg::def_h_total;
            vd_q    <= vga_pkg::def_v_disp;
            vf_q    <= vga_pkg::def_v_front;
            vs_q    <= vga_pkg::def_v_sync;
            vt_q    <= vga_pkg::def_v_total;
        end
        else if (wr_en)
        begin
            case (paddr)
                vga_pkg::reg_ctrl:   ctrl_q  <= pwdata[4:0];
                vga_pkg::reg_solid:  solid_q <= pwdata[8:0];
                vga_pkg::reg_barw:   barw_q  <= pwdata[10:0];
                vga_pkg::reg_htime0:
                begin
                    hd_q <= pwdata[10:0];
                    hf_q <= pwdata[26:16];
                end
                vga_pkg::reg_htime1:
                begin
                    hs_q <= pwdata[10:0];
                    ht_q <= pwdata[26:16];
                end
                vga_pkg::reg_vtime0:
                begin
                    vd_q <= pwdata[10:0];
                    vf_q <= pwdata[26:16];
                end
                vga_pkg::reg_vtime1:
                begin
                    vs_q <= pwdata[10:0];
                    vt_q <= pwdata[26:16];
                end
                default: ;                       // status, unmapped
            endcase
        end
    end

    // shadow timing, follows while idle, else only at frame wrap
    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
        begin
            h_disp  <= vga_pkg::def_h_disp;
            h_front <= vga_pkg::def_h_front;
            h_sync  <= vga_pkg::def_h_sync;
            h_total <= vga_pkg::def_h_total;
            v_disp  <= vga_pkg::def_v_disp;
            v_front <= vga_pkg::def_v_front;
            v_sync  <= vga_pkg::def_v_sync;
            v_total <= vga_pkg::def_v_total;
        end
        else if (!enable || frame_start)
        begin
            h_disp  <= hd_q;
            h_front <= hf_q;
            h_sync  <= hs_q;
            h_total <= ht_q;
            v_disp  <= vd_q;
            v_front <= vf_q;
            v_sync  <= vs_q;
            v_total <= vt_q;
        end
    end

    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
            frame_cnt <= '0;
        else if (frame_start)
            frame_cnt <= frame_cnt + 16'd1;      // wraps silently
    end

    assign enable = ctrl_q[vga_pkg::ctrl_enable];
    assign mode   = ctrl_q[vga_pkg::ctrl_mode +: 2];
    assign hs_pol = ctrl_q[vga_pkg::ctrl_hpol];
    assign vs_pol = ctrl_q[vga_pkg::ctrl_vpol];
    assign solid  = solid_q;                     // colour side not shadowed
    assign barw   = barw_q;

endmodule

// File: src/vga_scan_timer.sv
module vga_scan_timer (
    input  logic            clk_vga,
    input  logic            RST_N,
    input  logic            enable,
    input  vga_pkg::coord_t h_disp,
    input  vga_pkg::coord_t h_front,
    input  vga_pkg::coord_t h_sync,
    input  vga_pkg::coord_t h_total,
    input  vga_pkg::coord_t v_disp,
    input  vga_pkg::coord_t v_front,
    input  vga_pkg::coord_t v_sync,
    input  vga_pkg::coord_t v_total,
    output logic            hsync_raw,   // active high window
    output logic            vsync_raw,
    output logic            active,
    output vga_pkg::coord_t pix_x,       // 1 based, 0 when blanked
    output vga_pkg::coord_t pix_y,
    output logic            frame_start, // both counters wrapping
    output vga_pkg::coord_t line
);

    vga_pkg::coord_t h_cnt;
    vga_pkg::coord_t v_cnt;
    vga_pkg::coord_t h_last;
    vga_pkg::coord_t v_last;
    logic            h_wrap;
    logic            v_wrap;
    logic [11:0]     hs_beg, hs_end;     // one extra bit, sums can carry
    logic [11:0]     vs_beg, vs_end;
    logic            h_vis, v_vis;
    logic            h_in_sync, v_in_sync;

    assign h_last = h_total - 11'd1;
    assign v_last = v_total - 11'd1;
    assign h_wrap = (h_cnt >= h_last);   // >= so a shrunk total cannot run away
    assign v_wrap = (v_cnt >= v_last);

    // pixel counter
    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
            h_cnt <= '0;
        else if (!enable)
            h_cnt <= '0;                 // hold at origin
        else if (h_wrap)
            h_cnt <= '0;
        else
            h_cnt <= h_cnt + 11'd1;
    end

    // line counter, steps on h wrap
    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
            v_cnt <= '0;
        else if (!enable)
            v_cnt <= '0;
        else if (h_wrap)
        begin
            if (v_wrap)
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 11'd1;
        end
    end

    // lines up with the counter wrap, so the shadow load lands on pixel 0
    assign frame_start = enable & h_wrap & v_wrap;
    assign line = v_cnt;

    // sync windows [disp+front, disp+front+sync)
    assign hs_beg = h_disp + h_front;
    assign hs_end = hs_beg + h_sync;
    assign vs_beg = v_disp + v_front;
    assign vs_end = vs_beg + v_sync;

    assign h_vis = (h_cnt < h_disp);
    assign v_vis = (v_cnt < v_disp);
    assign h_in_sync = ({1'b0, h_cnt} >= hs_beg) && ({1'b0, h_cnt} < hs_end);
    assign v_in_sync = ({1'b0, v_cnt} >= vs_beg) && ({1'b0, v_cnt} < vs_end);

    // registered outputs, one cycle behind counters
    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
        begin
            hsync_raw <= 1'b0;
            vsync_raw <= 1'b0;
            active    <= 1'b0;
            pix_x     <= '0;
            pix_y     <= '0;
        end
        else
        begin
            hsync_raw <= enable & h_in_sync;
            vsync_raw <= enable & v_in_sync;
            active    <= enable & h_vis & v_vis;
            if (enable && h_vis && v_vis)
            begin
                pix_x <= h_cnt + 11'd1;  // 1..h_disp
                pix_y <= v_cnt + 11'd1;  // 1..v_disp
            end
            else
            begin
                pix_x <= '0;
                pix_y <= '0;
            end
        end
    end

endmodule

// File: src/vga_pixel_out.sv
module vga_pixel_out (
    input  logic            clk_vga,
    input  logic            RST_N,
    input  logic [1:0]      mode,
    input  logic            hs_pol,     // 1 inverts hsync
    input  logic            vs_pol,
    input  vga_pkg::rgb9_t  solid,
    input  vga_pkg::coord_t barw,
    input  logic            active,
    input  vga_pkg::coord_t pix_x,
    input  logic            hsync_raw,
    input  logic            vsync_raw,
    input  vga_pkg::rgb9_t  rgb,        // external source, same cycle
    output logic            vga_hsync,
    output logic            vga_vsync,
    output vga_pkg::chan4_t vga_red,
    output vga_pkg::chan4_t vga_green,
    output vga_pkg::chan4_t vga_blue
);

    vga_pkg::coord_t bar_cnt;           // pixels into current bar
    logic [2:0]      bar_idx;           // wraps after 8 bars
    vga_pkg::coord_t cnt_cur;
    logic [2:0]      idx_cur;
    logic            line_first;
    logic            bar_done;
    vga_pkg::rgb9_t  pix;

    // 3 bit to 4 bit, repeat msb into lsb
    function automatic vga_pkg::chan4_t expand(input logic [2:0] c);
        return {c, c[2]};
    endfunction

    // restart on x == 1 too, active may not drop with zero h blanking
    assign line_first = (pix_x == 11'd1);
    assign cnt_cur = line_first ? '0 : bar_cnt;
    assign idx_cur = line_first ? 3'd0 : bar_idx;
    assign bar_done = ({1'b0, cnt_cur} + 12'd1 >= {1'b0, barw});  // barw 0 acts as 1

    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
        begin
            bar_cnt <= '0;
            bar_idx <= '0;
        end
        else if (!active)
        begin
            bar_cnt <= '0;              // back to white each line
            bar_idx <= '0;
        end
        else if (bar_done)
        begin
            bar_cnt <= '0;
            bar_idx <= idx_cur + 3'd1;
        end
        else
        begin
            bar_cnt <= cnt_cur + 11'd1;
            bar_idx <= idx_cur;
        end
    end

    // source select
    always_comb
    begin
        case (mode)
            vga_pkg::mode_ext:   pix = rgb;
            vga_pkg::mode_solid: pix = solid;
            vga_pkg::mode_bars:  pix = vga_pkg::bar_colors[idx_cur];
            vga_pkg::mode_blank: pix = '0;
            default:             pix = '0;
        endcase
    end

    // single output register, syncs delayed alongside colour
    always_ff @(posedge clk_vga or negedge RST_N)
    begin
        if (!RST_N)
        begin
            vga_hsync <= 1'b0;          // reset polarity 0, idle low
            vga_vsync <= 1'b0;
            vga_red   <= '0;
            vga_green <= '0;
            vga_blue  <= '0;
        end
        else
        begin
            vga_hsync <= hsync_raw ^ hs_pol;
            vga_vsync <= vsync_raw ^ vs_pol;
            vga_red   <= active ? expand(pix[8:6]) : '0;  // black in blanking
            vga_green <= active ? expand(pix[5:3]) : '0;
            vga_blue  <= active ? expand(pix[2:0]) : '0;
        end
    end

endmodule

// File: src/vga_line_top.sv
module vga_line_top (
    input  logic               clk_vga,
    input  logic               RST_N,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  vga_pkg::apb_addr_t paddr,
    input  vga_pkg::apb_data_t pwdata,
    output vga_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output vga_pkg::coord_t    pix_x,      // to pixel source
    output vga_pkg::coord_t    pix_y,
    output logic               pix_req,    // same as active
    input  vga_pkg::rgb9_t     rgb,        // answer, same cycle
    output logic               vga_hsync,
    output logic               vga_vsync,
    output vga_pkg::chan4_t    vga_red,
    output vga_pkg::chan4_t    vga_green,
    output vga_pkg::chan4_t    vga_blue
);

    logic            enable;
    logic [1:0]      mode;
    logic            hs_pol, vs_pol;
    vga_pkg::rgb9_t  solid;
    vga_pkg::coord_t barw;
    vga_pkg::coord_t h_disp, h_front, h_sync, h_total;  // shadowed timing
    vga_pkg::coord_t v_disp, v_front, v_sync, v_total;
    logic            frame_start;
    vga_pkg::coord_t line;
    logic            hsync_raw, vsync_raw;

    vga_apb_regs regs_i (
        .clk_vga(clk_vga), .RST_N(RST_N),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .frame_start(frame_start), .line(line),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .enable(enable), .mode(mode), .hs_pol(hs_pol), .vs_pol(vs_pol),
        .solid(solid), .barw(barw),
        .h_disp(h_disp), .h_front(h_front), .h_sync(h_sync), .h_total(h_total),
        .v_disp(v_disp), .v_front(v_front), .v_sync(v_sync), .v_total(v_total)
    );

    vga_scan_timer timer_i (
        .clk_vga(clk_vga), .RST_N(RST_N), .enable(enable),
        .h_disp(h_disp), .h_front(h_front), .h_sync(h_sync), .h_total(h_total),
        .v_disp(v_disp), .v_front(v_front), .v_sync(v_sync), .v_total(v_total),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .active(pix_req),
        .pix_x(pix_x), .pix_y(pix_y),
        .frame_start(frame_start), .line(line)
    );

    vga_pixel_out out_i (
        .clk_vga(clk_vga), .RST_N(RST_N),
        .mode(mode), .hs_pol(hs_pol), .vs_pol(vs_pol),
        .solid(solid), .barw(barw),
        .active(pix_req), .pix_x(pix_x),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .rgb(rgb),
        .vga_hsync(vga_hsync), .vga_vsync(vga_vsync),
        .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue)
    );

endmodule

// File: dv/vga_line_asserts.sv
module vga_line_asserts (
    input logic            clk_vga,
    input logic            RST_N,
    input logic            psel,
    input logic            penable,
    input logic            pready,
    input logic            pix_req,
    input logic            vga_vsync,
    input logic            vs_pol,      // 1 means active low vsync
    input vga_pkg::chan4_t vga_red,
    input vga_pkg::chan4_t vga_green,
    input vga_pkg::chan4_t vga_blue
);

    // no wait states on this slave
    apb_no_wait: assert property (@(posedge clk_vga) disable iff (!RST_N)
        (psel && penable) |-> pready)
        else $error("apb access phase seen without pready");

    // vsync sits outside the display lines in every test mode
    req_outside_vsync: assert property (@(posedge clk_vga) disable iff (!RST_N)
        pix_req |-> (vga_vsync == vs_pol))
        else $error("pixel request while vsync is at its active level");

    // blanking reaches the dac one cycle later
    blank_is_black: assert property (@(posedge clk_vga) disable iff (!RST_N)
        !pix_req |=> (vga_red == 4'd0 && vga_green == 4'd0 && vga_blue == 4'd0))
        else $error("colour output not black one cycle after blanking");

endmodule

bind vga_line_top vga_line_asserts asserts_i (
    .clk_vga(clk_vga), .RST_N(RST_N),
    .psel(psel), .penable(penable), .pready(pready),
    .pix_req(pix_req), .vga_vsync(vga_vsync), .vs_pol(vs_pol),
    .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue)
);

// File: dv/vga_line_tb.sv
module vga_line_tb;

    logic               clk_vga;
    logic               RST_N;
    logic               psel, penable, pwrite;
    vga_pkg::apb_addr_t paddr;
    vga_pkg::apb_data_t pwdata;
    vga_pkg::apb_data_t prdata;
    logic               pready, pslverr;
    vga_pkg::coord_t    pix_x, pix_y;
    logic               pix_req;
    vga_pkg::rgb9_t     rgb;
    vga_pkg::coord_t    sum_xy;
    logic               vga_hsync, vga_vsync;
    vga_pkg::chan4_t    vga_red, vga_green, vga_blue;

    int     errors, test_errors, tests, failed_tests;
    string  test_name;
    longint limit_cycles;
    int     e_ht, e_vt, e_mode;            // expected frame, from F line
    vga_pkg::rgb9_t e_val;                 // solid colour
    vga_pkg::coord_t e_barw;               // bar width in pixels
    logic   e_hpol, e_vpol;
    longint win, cyc;                      // measure window in cycles
    logic   mon_arm, mon_run;
    logic   p_req;                         // previous cycle, for colour check
    vga_pkg::coord_t p_x, p_y;
    logic   m_hs, m_vs, m_req, have_rise;
    longint last_rise;
    int     hw, vw, aw, a_lines;
    int     per_mn, per_mx, hw_mn, hw_mx, vl_mn, vl_mx, aw_mn, aw_mx;
    vga_pkg::apb_addr_t pend_addr[$];      // writes applied mid frame
    vga_pkg::apb_data_t pend_data[$];

    vga_line_top dut_i (.*);

    // pixel source, answers in the same cycle
    assign sum_xy = pix_x + pix_y;
    assign rgb = {pix_x[2:0], pix_y[2:0], sum_xy[2:0]};

    initial
    begin
        clk_vga = 1'b0;
        forever #4 clk_vga = ~clk_vga;
    end

    function automatic vga_pkg::chan4_t widen(input logic [2:0] c);
        return {c, c[2]};                  // msb repeated into lsb
    endfunction

    function automatic vga_pkg::rgb9_t bar_color(input int idx);
        case (idx)
            0: return 9'o777;              // white
            1: return 9'o700;              // red
            2: return 9'o707;              // magenta
            3: return 9'o770;              // yellow
            4: return 9'o070;              // green
            5: return 9'o007;              // blue
            6: return 9'o077;              // cyan
            default: return 9'o000;        // black
        endcase
    endfunction

    function automatic vga_pkg::rgb9_t source_colour(input vga_pkg::coord_t x,
                                                     input vga_pkg::coord_t y);
        vga_pkg::coord_t s;
        s = x + y;
        case (e_mode)
            0: return {x[2:0], y[2:0], s[2:0]};
            1: return e_val;
            2: return bar_color(((int'(x) - 1) / int'(e_barw)) % 8);
            default: return '0;            // blank mode
        endcase
    endfunction

    task automatic check_data(input string name, input vga_pkg::apb_data_t got,
                              input vga_pkg::apb_data_t exp);
        if (got !== exp)
        begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_coord(input string name, input vga_pkg::coord_t got,
                               input vga_pkg::coord_t exp);
        if (got !== exp)
        begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_chan(input string name, input vga_pkg::chan4_t got,
                              input vga_pkg::chan4_t exp);
        if (got !== exp)
        begin
            if (errors < 40)               // keep a broken frame readable
                $display("Fail %s: got %h, expected %h at cycle %0d", name, got, exp, cyc);
            errors++;
            test_errors++;
        end
    endtask

    task automatic track_range(input int v, inout int mn, inout int mx);
        if (v < mn)
            mn = v;
        if (v > mx)
            mx = v;
    endtask

    // one cycle of the scan monitor, called from the negedge process
    task automatic scan_sample();
        logic hs_act, vs_act;
        vga_pkg::rgb9_t exp;
        hs_act = vga_hsync ^ e_hpol;       // 1 while pulse is on
        vs_act = vga_vsync ^ e_vpol;
        if (hs_act && !m_hs)
        begin
            if (have_rise)
                track_range(int'(cyc - last_rise), per_mn, per_mx);
            last_rise = cyc;
            have_rise = 1'b1;
        end
        if (hs_act)
            hw++;
        else if (m_hs)
        begin
            track_range(hw, hw_mn, hw_mx);
            hw = 0;
        end
        if (vs_act)
            vw++;
        else if (m_vs)
        begin
            track_range(vw / e_ht, vl_mn, vl_mx);  // whole lines
            vw = 0;
        end
        if (pix_req)
        begin
            aw++;
            if (!m_req)
                a_lines++;
        end
        else if (m_req)
        begin
            track_range(aw, aw_mn, aw_mx);
            aw = 0;
        end
        m_hs = hs_act;
        m_vs = vs_act;
        m_req = pix_req;
        exp = p_req ? source_colour(p_x, p_y) : '0;  // output lags by one
        check_chan("vga_red", vga_red, widen(exp[8:6]));
        check_chan("vga_green", vga_green, widen(exp[5:3]));
        check_chan("vga_blue", vga_blue, widen(exp[2:0]));
    endtask

    // monitor, starts at the first pixel of a frame once armed
    always @(negedge clk_vga)
    begin
        if (mon_arm && !mon_run && pix_req && pix_x == 11'd1 && pix_y == 11'd1)
        begin
            mon_run = 1'b1;
            cyc = 0;
            m_hs = vga_hsync ^ e_hpol;
            m_vs = vga_vsync ^ e_vpol;
            m_req = 1'b0;
            have_rise = 1'b0;
            hw = 0;
            vw = 0;
            aw = 0;
            a_lines = 0;
            per_mn = 1 << 30;
            hw_mn = 1 << 30;
            vl_mn = 1 << 30;
            aw_mn = 1 << 30;
            per_mx = 0;
            hw_mx = 0;
            vl_mx = 0;
            aw_mx = 0;
        end
        if (mon_run)
        begin
            scan_sample();
            cyc++;
            if (cyc == win)
            begin
                mon_run = 1'b0;
                mon_arm = 1'b0;
            end
        end
        p_req = pix_req;
        p_x = pix_x;
        p_y = pix_y;
    end

    // one apb transfer, entered and left on a falling edge
    task automatic apb_xfer(input logic wr, input vga_pkg::apb_addr_t a,
                            input vga_pkg::apb_data_t d,
                            output vga_pkg::apb_data_t rd, output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = a;
        pwdata = d;
        @(negedge clk_vga);
        penable = 1'b1;
        #2;                                // mid access phase
        rd = prdata;
        err = pslverr;
        @(negedge clk_vga);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic run_frames(input int n, input int hs, input int hd,
                              input int vs, input int vd);
        vga_pkg::apb_data_t fc0, fc1, scratch;
        logic er;
        win = longint'(n) * e_ht * e_vt;
        mon_arm = 1'b1;
        wait (mon_run);
        apb_xfer(1'b0, vga_pkg::reg_status, '0, fc0, er);
        if (pend_addr.size() > 0)
        begin
            repeat (2 * e_ht) @(negedge clk_vga);  // a couple of lines in
            foreach (pend_addr[i])
                apb_xfer(1'b1, pend_addr[i], pend_data[i], scratch, er);
            pend_addr.delete();
            pend_data.delete();
        end
        wait (!mon_run);
        apb_xfer(1'b0, vga_pkg::reg_status, '0, fc1, er);
        check_data("frame_count_delta", {16'd0, fc1[31:16]} - {16'd0, fc0[31:16]}, n);
        check_coord("hsync_period_min", per_mn, e_ht);
        check_coord("hsync_period_max", per_mx, e_ht);
        check_coord("hsync_width_min", hw_mn, hs);
        check_coord("hsync_width_max", hw_mx, hs);
        check_coord("vsync_lines_min", vl_mn, vs);
        check_coord("vsync_lines_max", vl_mx, vs);
        check_coord("active_pixels_min", aw_mn, hd);
        check_coord("active_pixels_max", aw_mx, hd);
        check_coord("active_lines", a_lines, vd * n);
    endtask

    task automatic finish_test();
        if (test_name != "")
        begin
            tests++;
            if (test_errors == 0)
                $display("test %s: passed", test_name);
            else
            begin
                $display("test %s: %0d errors", test_name, test_errors);
                failed_tests++;
            end
        end
        test_errors = 0;
    endtask

    initial
    begin
        int fd, fn, ht, hs, hd, vt, vs, vd, cm, hp, vp, a, e, cnt;
        string ln, cmd, nm;
        vga_pkg::apb_data_t d, mask, rd, v;
        logic er;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        RST_N = 1'b0;
        mon_arm = 1'b0;
        mon_run = 1'b0;
        errors = 0;
        test_errors = 0;
        tests = 0;
        failed_tests = 0;
        test_name = "";
        limit_cycles = 0;
        v = $urandom(32'he2c0_6eb6);       // seed once
        fd = $fopen("dv/vga_line_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file dv/vga_line_stimulus.txt");
            errors++;
        end
        // first pass sizes the watchdog from the frame lengths
        while (fd != 0 && $fgets(ln, fd) != 0)
        begin
            if (ln.len() < 2 || ln.substr(0, 0) == "#")
                continue;
            cnt = $sscanf(ln, "%s %d %d %d %d %d", cmd, fn, ht, hs, hd, vt);
            if (cmd == "F")
                limit_cycles += longint'(fn + 3) * ht * vt;
            limit_cycles += 200;
        end
        if (fd != 0)
            $fclose(fd);
        limit_cycles += 1000;              // reset and margin
        fd = $fopen("dv/vga_line_stimulus.txt", "r");
        repeat (5) @(negedge clk_vga);
        RST_N = 1'b1;
        @(negedge clk_vga);
        while (fd != 0 && $fgets(ln, fd) != 0)
        begin
            if (ln.len() < 2 || ln.substr(0, 0) == "#")
                continue;
            cnt = $sscanf(ln, "%s", cmd);
            if (cmd == "T")
            begin
                finish_test();
                cnt = $sscanf(ln, "%s %s", cmd, nm);
                test_name = nm;
            end
            else if (cmd == "W")
            begin
                cnt = $sscanf(ln, "%s %h %h %h", cmd, a, d, e);
                apb_xfer(1'b1, a[4:0], d, rd, er);
                check_err("pslverr", er, e[0]);
            end
            else if (cmd == "R")
            begin
                cnt = $sscanf(ln, "%s %h %h %h", cmd, a, d, e);
                apb_xfer(1'b0, a[4:0], '0, rd, er);
                check_data("prdata", rd, d);
                check_err("pslverr", er, e[0]);
            end
            else if (cmd == "Z")
            begin
                cnt = $sscanf(ln, "%s %h %h %d", cmd, a, mask, fn);
                repeat (fn)
                begin
                    v = $urandom;
                    apb_xfer(1'b1, a[4:0], v, rd, er);
                    apb_xfer(1'b0, a[4:0], '0, rd, er);
                    check_data("prdata", rd, v & mask);
                    check_err("pslverr", er, 1'b0);
                end
            end
            else if (cmd == "S")
            begin
                cnt = $sscanf(ln, "%s %d %d", cmd, hp, vp);
                repeat (3) @(negedge clk_vga);
                check_err("vga_hsync", vga_hsync, hp[0]);
                check_err("vga_vsync", vga_vsync, vp[0]);
                check_err("pix_req", pix_req, 1'b0);
                check_chan("vga_red", vga_red, '0);
                check_chan("vga_green", vga_green, '0);
                check_chan("vga_blue", vga_blue, '0);
            end
            else if (cmd == "P")
            begin
                cnt = $sscanf(ln, "%s %h %h", cmd, a, d);
                pend_addr.push_back(a[4:0]);
                pend_data.push_back(d);
            end
            else if (cmd == "F")
            begin
                cnt = $sscanf(ln, "%s %d %d %d %d %d %d %d %d %h %d %d",
                              cmd, fn, ht, hs, hd, vt, vs, vd, cm, d, hp, vp);
                e_ht = ht;
                e_vt = vt;
                e_mode = cm;
                e_val = d[8:0];
                e_barw = d[10:0];
                e_hpol = hp[0];
                e_vpol = vp[0];
                run_frames(fn, hs, hd, vs, vd);
            end
            else
            begin
                $display("unknown stimulus command in line: %s", ln);
                errors++;
            end
        end
        if (fd != 0)
            $fclose(fd);
        finish_test();
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // watchdog, limit comes from the first pass over the file
    initial
    begin
        wait (limit_cycles > 0);
        #(limit_cycles * 8);
        $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: dv/vga_line_stimulus.txt
# T name | W addr data err | R addr data err | Z addr mask count | S hsync vsync | P addr data
# F frames h_total h_sync h_disp v_total v_sync v_disp mode value(hex) hpol vpol
T reset_defaults
S 0 0
R 00 00000000 0
R 04 00000000 0
R 08 000000a0 0
R 0c 00300500 0
R 10 06980070 0
R 14 00010400 0
R 18 042a0003 0
R 1c 00000000 0
W 00 00000018 0
S 1 1
W 00 00000000 0
S 0 0
T register_access
Z 04 000001ff 4
Z 08 000007ff 4
Z 0c 07ff07ff 4
Z 10 07ff07ff 4
Z 14 07ff07ff 4
Z 18 07ff07ff 4
W 04 00000155 0
W 1c 12345678 1
W 06 ffffffff 1
R 04 00000155 0
R 02 00000000 1
T scan_timing
W 0c 00020010 0
W 10 001e0004 0
W 14 00010008 0
W 18 000e0002 0
W 00 00000001 0
F 2 30 4 16 14 2 8 0 0 0 0
W 00 00000000 0
W 00 00000019 0
F 1 30 4 16 14 2 8 0 0 1 1
W 00 00000018 0
W 00 00000000 0
T external_mode
W 00 00000001 0
F 2 30 4 16 14 2 8 0 0 0 0
T solid_and_bars
W 04 000001a5 0
W 00 00000003 0
F 1 30 4 16 14 2 8 1 1a5 0 0
W 08 00000002 0
W 00 00000005 0
F 1 30 4 16 14 2 8 2 2 0 0
W 08 00000003 0
F 1 30 4 16 14 2 8 2 3 0 0
W 00 00000007 0
F 1 30 4 16 14 2 8 3 0 0 0
T frame_shadow
W 00 00000001 0
P 0c 00030014
P 10 00240005
P 14 0002000a
P 18 00110003
F 1 30 4 16 14 2 8 0 0 0 0
F 2 36 5 20 17 3 10 0 0 0 0
R 0c 00030014 0

// File: project.f
src/vga_pkg.sv
src/vga_apb_regs.sv
src/vga_scan_timer.sv
src/vga_pixel_out.sv
src/vga_line_top.sv
dv/vga_line_asserts.sv
dv/vga_line_tb.sv

// File: Makefile
SIM  = obj_dir/Vvga_line_tb
SRCS = $(shell cat project.f)

.PHONY: all run clean

all: run

$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module vga_line_tb -o Vvga_line_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
